// ==== logic/spi_pkg.sv ====
package spi_pkg;

    ////////////////////////////////////////////////////////////
    // transfer engine states
    ////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        st_idle   = 2'b00,  // ss_n high, waiting for start
        st_shift  = 2'b01,  // sclk running, bits moving
        st_finish = 2'b10   // one cycle, done pulse
    } spi_state_e;

    ////////////////////////////////////////////////////////////
    // apb register map, byte offsets
    ////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        reg_ctrl   = 4'h0,  // cdiv, msb_first
        reg_txdata = 4'h4,  // write starts a transfer
        reg_rxdata = 4'h8,  // last received byte
        reg_status = 4'hc   // busy, sticky done
    } apb_reg_e;

    // divider select, sclk = sck / (4 << cdiv)
    typedef logic [1:0] cdiv_t;

    // half of one sclk period, in sck cycles
    function automatic logic [4:0] half_period(input cdiv_t cdiv);
        logic [4:0] hp;
        case (cdiv)
            2'd0:    hp = 5'd2;
            2'd1:    hp = 5'd4;
            2'd2:    hp = 5'd8;
            default: hp = 5'd16;
        endcase
        return hp;
    endfunction

endpackage

// ==== logic/spi_ctrl_if.sv ====
`timescale 1ns/1ns

// command and status path, register block <-> shift engine
interface spi_ctrl_if #(
    parameter int data_width = 8
);
    import spi_pkg::*;

    ////////////////////////////////////////////////////////////
    // regs -> engine
    ////////////////////////////////////////////////////////////
    logic                  start;      // one cycle, only while !busy
    logic [data_width-1:0] tx_data;    // byte to send
    logic                  msb_first;  // bit order
    cdiv_t                 cdiv;       // sclk divider select

    ////////////////////////////////////////////////////////////
    // engine -> regs
    ////////////////////////////////////////////////////////////
    logic                  busy;       // high from ss_n fall to ss_n rise
    logic                  done;       // one cycle pulse
    logic [data_width-1:0] rx_data;    // valid with done

    modport regs (
        output start, tx_data, msb_first, cdiv,
        input  busy, done, rx_data
    );

    modport engine (
        input  start, tx_data, msb_first, cdiv,
        output busy, done, rx_data
    );

endinterface

// ==== logic/spi_apb_regs.sv ====
`timescale 1ns/1ns

module spi_apb_regs #(
    parameter int data_width = 8,
    parameter int addr_width = 4
) (
    input  logic                  sck,
    input  logic                  clr,
    // apb slave side
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [addr_width-1:0] paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    // towards the shift engine
    spi_ctrl_if.regs              ctl
);
    import spi_pkg::*;

    apb_reg_e              reg_sel;     // decoded word offset
    logic                  wr_access;   // access phase of a write
    logic                  wr_ctrl;
    logic                  wr_tx;
    logic                  wr_status;
    logic                  wr_tx_ok;    // tx write that may start a transfer

    cdiv_t                 cdiv_q;      // CTRL[1:0]
    logic                  msb_q;       // CTRL[2]
    logic [data_width-1:0] txdata_q;
    logic [data_width-1:0] rxdata_q;
    logic                  done_flag;   // sticky, STATUS[1]
    logic                  start_q;

    ////////////////////////////////////////////////////////////
    // address decode
    ////////////////////////////////////////////////////////////
    assign reg_sel   = apb_reg_e'(paddr[3:0]);  // upper bits ignored
    assign wr_access = psel && penable && pwrite;

    always_comb begin
        wr_ctrl   = 1'b0;
        wr_tx     = 1'b0;
        wr_status = 1'b0;
        case (reg_sel)
            reg_ctrl:   wr_ctrl   = wr_access;
            reg_txdata: wr_tx     = wr_access;
            reg_status: wr_status = wr_access;
            default:    ;  // rxdata and holes are read only
        endcase
    end

    // a pending start also blocks, it has not raised busy yet
    assign wr_tx_ok = wr_tx && !ctl.busy && !ctl.start;

    assign pready  = 1'b1;                 // no wait states
    assign pslverr = wr_tx && ctl.busy;    // refused tx write

    ////////////////////////////////////////////////////////////
    // register state
    ////////////////////////////////////////////////////////////
    always_ff @(posedge sck or posedge clr) begin
        if (clr) begin
            cdiv_q    <= '0;
            msb_q     <= 1'b0;
            txdata_q  <= '0;
            rxdata_q  <= '0;
            done_flag <= 1'b0;
            start_q   <= 1'b0;
        end else begin
            start_q <= wr_tx_ok;  // start one cycle after the access
            if (wr_ctrl) begin
                cdiv_q <= cdiv_t'(pwdata[1:0]);
                msb_q  <= pwdata[2];
            end
            if (wr_tx_ok) begin
                txdata_q <= pwdata[data_width-1:0];
            end
            if (ctl.done) begin
                rxdata_q  <= ctl.rx_data;  // capture with the pulse
                done_flag <= 1'b1;         // set beats clear
            end else if (wr_status && pwdata[1]) begin
                done_flag <= 1'b0;         // write 1 to clear
            end
        end
    end

    assign ctl.start     = start_q;
    assign ctl.tx_data   = txdata_q;
    assign ctl.msb_first = msb_q;
    assign ctl.cdiv      = cdiv_q;

    ////////////////////////////////////////////////////////////
    // read mux
    ////////////////////////////////////////////////////////////
    always_comb begin
        prdata = '0;
        case (reg_sel)
            reg_ctrl:   prdata[2:0] = {msb_q, cdiv_q};
            reg_txdata: prdata[data_width-1:0] = txdata_q;
            reg_rxdata: prdata[data_width-1:0] = rxdata_q;
            reg_status: prdata[1:0] = {done_flag, ctl.busy};
            default:    prdata = '0;
        endcase
    end

    // engine must never see a start mid transfer
    a_no_start_busy: assert property (
        @(posedge sck) disable iff (clr) ctl.start |-> !ctl.busy
    ) else $error("start issued while engine busy");

endmodule

// ==== logic/spi_clk_gen.sv ====
`timescale 1ns/1ns

module spi_clk_gen (
    input  logic           sck,
    input  logic           clr,
    input  logic           enable,     // high while the engine shifts
    input  spi_pkg::cdiv_t cdiv,       // latched divider select
    output logic           sclk,       // idles high, mode 3
    output logic           sclk_rise,  // sclk goes high at this edge
    output logic           sclk_fall   // sclk goes low at this edge
);
    import spi_pkg::*;

    logic [4:0] cnt;      // sck cycles into the current half period
    logic [4:0] last;     // terminal count
    logic       toggle;

    ////////////////////////////////////////////////////////////
    // half period counter
    ////////////////////////////////////////////////////////////
    assign last   = half_period(cdiv) - 5'd1;
    assign toggle = enable && (cnt == last);

    // strobes lead the registered sclk by the edge that flips it
    assign sclk_fall = toggle && sclk;
    assign sclk_rise = toggle && !sclk;

    always_ff @(posedge sck or posedge clr) begin
        if (clr) begin
            cnt  <= '0;
            sclk <= 1'b1;
        end else if (!enable) begin
            cnt  <= '0;     // restart fresh each transfer
            sclk <= 1'b1;   // park high
        end else if (toggle) begin
            cnt  <= '0;
            sclk <= ~sclk;  // first toggle is a fall
        end else begin
            cnt  <= cnt + 5'd1;
        end
    end

    // idle level when the engine is not shifting
    a_sclk_idle_high: assert property (
        @(posedge sck) disable iff (clr) !enable |-> sclk
    ) else $error("sclk low while divider disabled");

endmodule

// ==== logic/spi_shifter.sv ====
`timescale 1ns/1ns

module spi_shifter #(
    parameter int data_width = 8
) (
    input  logic        sck,
    input  logic        clr,
    spi_ctrl_if.engine  ctl,
    // spi pins, mode 3
    output logic        sclk,
    output logic        ss_n,
    output logic        mosi,
    input  logic        miso
);
    import spi_pkg::*;

    localparam int cnt_w = $clog2(data_width) + 1;

    spi_state_e            state;
    spi_state_e            state_nxt;
    cdiv_t                 cdiv_q;     // held for the whole transfer
    logic                  msb_q;
    logic [cnt_w-1:0]      bit_cnt;    // rising edges seen
    logic [data_width-1:0] tx_sr;
    logic [data_width-1:0] rx_sr;
    logic                  load;       // start accepted this cycle
    logic                  shift_out;  // fall that moves mosi
    logic                  last_rise;  // final sampling edge
    logic                  shift_en;
    logic                  sclk_rise;
    logic                  sclk_fall;

    ////////////////////////////////////////////////////////////
    // transfer FSM
    ////////////////////////////////////////////////////////////
    assign load      = (state == st_idle) && ctl.start;
    assign last_rise = sclk_rise && (bit_cnt == cnt_w'(data_width - 1));
    // first fall only ends the lead half, bit already on mosi
    assign shift_out = sclk_fall && (bit_cnt != '0);
    assign shift_en  = (state == st_shift);

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:   if (ctl.start) state_nxt = st_shift;
            st_shift:  if (last_rise) state_nxt = st_finish;
            st_finish: state_nxt = st_idle;   // done goes out here
            default:   state_nxt = st_idle;
        endcase
    end

    assign ctl.busy    = (state != st_idle);
    assign ctl.done    = (state == st_finish);
    assign ctl.rx_data = rx_sr;   // complete in the finish cycle

    ////////////////////////////////////////////////////////////
    // control registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge sck or posedge clr) begin
        if (clr) begin
            state   <= st_idle;
            cdiv_q  <= '0;
            msb_q   <= 1'b0;
            bit_cnt <= '0;
            ss_n    <= 1'b1;
            mosi    <= 1'b1;
        end else begin
            state <= state_nxt;
            if (load) begin
                cdiv_q  <= ctl.cdiv;        // later CTRL writes wait
                msb_q   <= ctl.msb_first;
                bit_cnt <= '0;
                ss_n    <= 1'b0;
                mosi    <= ctl.msb_first ? ctl.tx_data[data_width-1] : ctl.tx_data[0];
            end else if (state == st_finish) begin
                ss_n <= 1'b1;               // deselect, back to idle
                mosi <= 1'b1;
            end else begin
                if (sclk_rise) begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
                if (shift_out) begin
                    mosi <= msb_q ? tx_sr[data_width-2] : tx_sr[1];  // next bit
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // shift registers, payload only
    ////////////////////////////////////////////////////////////
    always_ff @(posedge sck) begin
        if (load) begin
            tx_sr <= ctl.tx_data;
        end else if (shift_out) begin
            tx_sr <= msb_q ? {tx_sr[data_width-2:0], 1'b1}   // msb leaves first
                           : {1'b1, tx_sr[data_width-1:1]};  // lsb leaves first
        end
        if (sclk_rise) begin
            rx_sr <= msb_q ? {rx_sr[data_width-2:0], miso}
                           : {miso, rx_sr[data_width-1:1]};
        end
    end

    // sclk divider, runs only in st_shift
    spi_clk_gen i_clk_gen (
        .sck       (sck),
        .clr       (clr),
        .enable    (shift_en),
        .cdiv      (cdiv_q),
        .sclk      (sclk),
        .sclk_rise (sclk_rise),
        .sclk_fall (sclk_fall)
    );

    // slave sees clock activity only while selected
    a_sclk_low_selected: assert property (
        @(posedge sck) disable iff (clr) !sclk |-> !ss_n
    ) else $error("sclk low with ss_n high");

endmodule

// ==== logic/spi_master_top.sv ====
`timescale 1ns/1ns

module spi_master_top #(
    parameter int data_width = 8,
    parameter int addr_width = 4
) (
    input  logic                  sck,
    input  logic                  clr,
    // apb
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [addr_width-1:0] paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    // spi
    output logic                  sclk,
    output logic                  ss_n,
    output logic                  mosi,
    input  logic                  miso
);

    ////////////////////////////////////////////////////////////
    // regs <-> engine link
    ////////////////////////////////////////////////////////////
    spi_ctrl_if #(.data_width(data_width)) i_ctl ();

    // apb front end
    spi_apb_regs #(
        .data_width (data_width),
        .addr_width (addr_width)
    ) i_regs (
        .sck     (sck),
        .clr     (clr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .ctl     (i_ctl.regs)
    );

    // fsm, shift regs, sclk divider
    spi_shifter #(.data_width(data_width)) i_shifter (
        .sck  (sck),
        .clr  (clr),
        .ctl  (i_ctl.engine),
        .sclk (sclk),
        .ss_n (ss_n),
        .mosi (mosi),
        .miso (miso)
    );

endmodule

// ==== tb/spi_slave_model.sv ====
`timescale 1ns/1ns

// mode 3 slave: samples mosi on rising sclk, drives miso after falling sclk
module spi_slave_model (
    input  logic       sclk,
    input  logic       ss_n,
    input  logic       mosi,
    output logic       miso,
    input  logic       msb_first,  // bit order, both directions
    input  logic [7:0] reply,      // byte sent back on miso
    output logic [7:0] rx_byte     // last byte seen on mosi
);

    logic [7:0] rx_sr   = 8'h00;
    logic [7:0] tx_byte = 8'hff;
    logic [7:0] rx_last = 8'h00;
    logic       msb_q   = 1'b1;
    int         rises   = 0;       // rising edges in this window
    int         out_idx = 0;       // bit now on miso

    function automatic logic pick_bit(input logic [7:0] b, input logic msb, input int idx);
        return msb ? b[7 - idx] : b[idx];
    endfunction

    ////////////////////////////////////////////////////////////
    // transmit side
    ////////////////////////////////////////////////////////////
    always @(negedge sclk or negedge ss_n) begin
        if (sclk) begin            // ss_n fell, sclk still parked high
            tx_byte <= reply;
            msb_q   <= msb_first;
            out_idx <= 0;
        end else begin
            out_idx <= rises;      // next bit after each sample
        end
    end

    // released line reads high
    assign miso = (ss_n !== 1'b0) ? 1'b1 : pick_bit(tx_byte, msb_q, out_idx);

    ////////////////////////////////////////////////////////////
    // receive side
    ////////////////////////////////////////////////////////////
    always @(posedge sclk) begin
        if (ss_n === 1'b0) begin
            rx_sr <= msb_q ? {rx_sr[6:0], mosi} : {mosi, rx_sr[7:1]};
            rises <= (rises == 7) ? 0 : rises + 1;  // wraps on the last bit
        end
    end

    always @(posedge ss_n) begin
        rx_last <= rx_sr;          // byte complete on deselect
    end

    assign rx_byte = rx_last;

endmodule

// ==== tb/tb_spi_master.sv ====
`timescale 1ns/1ns

module tb_spi_master;

    // six tests of up to four slow transfers each plus margin
    localparam int         cycle_limit = 20000;
    localparam logic [3:0] a_ctrl      = 4'h0;
    localparam logic [3:0] a_tx        = 4'h4;
    localparam logic [3:0] a_rx        = 4'h8;
    localparam logic [3:0] a_status    = 4'hc;

    logic        sck;
    logic        clr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        sclk;
    logic        ss_n;
    logic        mosi;
    logic        miso;

    logic        slave_msb;
    logic [7:0]  slave_reply;
    logic [7:0]  slave_rx;
    logic [1:0]  ctrl_cdiv   = 2'd0;   // last cdiv written to CTRL
    logic [1:0]  launch_cdiv = 2'd0;   // cdiv in force at the last start
    int          pass_cnt    = 0;
    int          fail_cnt    = 0;
    int          test_fail   = 0;
    int          cycles      = 0;
    int          windows     = 0;      // ss_n low windows seen

    // sclk phase monitor state
    logic        prev_ss_n   = 1'b1;
    logic        prev_sclk   = 1'b1;
    int          run_len     = 0;
    int          rise_cnt    = 0;
    logic [4:0]  win_hp      = 5'd2;

    spi_master_top #(.data_width(8), .addr_width(4)) i_dut (
        .sck(sck), .clr(clr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .sclk(sclk), .ss_n(ss_n), .mosi(mosi), .miso(miso)
    );

    spi_slave_model i_slave (
        .sclk(sclk), .ss_n(ss_n), .mosi(mosi), .miso(miso),
        .msb_first(slave_msb), .reply(slave_reply), .rx_byte(slave_rx)
    );

    initial sck = 1'b0;
    always #10 sck = ~sck;  // 20 ns period

    always @(posedge sck) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run passed %0d cycles without finishing", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // sclk half period in sck cycles for each cdiv
    function automatic logic [4:0] expected_half(input logic [1:0] cdiv);
        return 5'd2 << cdiv;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            test_fail++;
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // concurrent checks
    ////////////////////////////////////////////////////////////
    a_pready_high: assert property (@(posedge sck) disable iff (clr) pready)
    else begin
        fail_cnt++;
        test_fail++;
        $display("pready went low, the bus would stall");
    end

    // mosi moves on falls only
    a_mosi_rise: assert property (@(posedge sck) disable iff (clr) $rose(sclk) |-> $stable(mosi))
    else begin
        fail_cnt++;
        test_fail++;
        $display("mosi changed at a rising sclk edge");
    end

    ////////////////////////////////////////////////////////////
    // sclk phase monitor sampled mid cycle
    ////////////////////////////////////////////////////////////
    always @(negedge sck) begin
        if (!ss_n) begin
            if (prev_ss_n) begin                     // new select window
                run_len  = 1;
                rise_cnt = 0;
                win_hp   = expected_half(launch_cdiv);
            end else if (sclk == prev_sclk) begin
                run_len++;
            end else begin
                check_val("sclk half period", run_len, win_hp);
                if (sclk) rise_cnt++;
                run_len = 1;
            end
        end else if (!prev_ss_n) begin               // window just closed
            check_val("sclk rises per ss_n window", rise_cnt, 8);
            windows++;
        end
        prev_ss_n = ss_n;
        prev_sclk = sclk;
    end

    ////////////////////////////////////////////////////////////
    // apb and transfer tasks
    ////////////////////////////////////////////////////////////
    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
        @(posedge sck);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge sck);
        penable <= 1'b1;
        @(negedge sck);
        err = pslverr;                                // access cycle
        @(posedge sck);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
        @(posedge sck);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge sck);
        penable <= 1'b1;
        @(negedge sck);
        data = prdata;
        @(posedge sck);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic set_ctrl(input logic msb, input logic [1:0] cdiv);
        logic err;
        apb_write(a_ctrl, {29'd0, msb, cdiv}, err);
        ctrl_cdiv = cdiv;
        slave_msb <= msb;                             // slave follows the order
    endtask

    task automatic start_transfer(input logic [7:0] tx, input logic [7:0] reply);
        logic err;
        slave_reply <= reply;
        launch_cdiv = ctrl_cdiv;
        apb_write(a_tx, {24'd0, tx}, err);
        check_val("pslverr", err, 32'd0);
    endtask

    task automatic wait_select();
        @(negedge sck);
        while (ss_n) @(negedge sck);
    endtask

    task automatic wait_deselect();
        while (!ss_n) @(negedge sck);                 // busy falls with ss_n
    endtask

    // data both ways then sticky done and its clear
    task automatic check_transfer(input logic [7:0] tx, input logic [7:0] reply);
        logic [31:0] rd;
        logic        err;
        check_val("slave rx byte", slave_rx, tx);
        apb_read(a_rx, rd);
        check_val("rxdata", rd, reply);
        apb_read(a_status, rd);
        check_val("status", rd, 32'h2);
        apb_write(a_status, 32'h2, err);
        apb_read(a_status, rd);
        check_val("status", rd, 32'h0);
    endtask

    task automatic do_transfer(input logic [7:0] tx, input logic [7:0] reply);
        start_transfer(tx, reply);
        wait_select();
        wait_deselect();
        check_transfer(tx, reply);
    endtask

    task automatic end_test(input string name);
        if (test_fail == 0) $display("test %s: ok", name);
        else $display("test %s: %0d error(s)", name, test_fail);
        test_fail = 0;
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] rd;
        logic        err;
        logic [7:0]  tx;
        logic [7:0]  rx;
        int          w0;
        void'($urandom(32'h9ee3));
        clr         <= 1'b1;
        psel        <= 1'b0;
        penable     <= 1'b0;
        pwrite      <= 1'b0;
        paddr       <= 4'h0;
        pwdata      <= 32'h0;
        slave_msb   <= 1'b1;
        slave_reply <= 8'h00;
        repeat (16) @(posedge sck);
        clr <= 1'b0;

        @(negedge sck);                               // idle levels
        check_val("ss_n", ss_n, 32'd1);
        check_val("sclk", sclk, 32'd1);
        check_val("mosi", mosi, 32'd1);
        apb_read(a_status, rd);
        check_val("status", rd, 32'h0);
        apb_read(a_ctrl, rd);
        check_val("ctrl", rd, 32'h0);
        end_test("reset values");

        set_ctrl(1'b1, 2'd0);
        do_transfer(8'h3a, 8'hc5);
        end_test("msb first at cdiv 0");

        set_ctrl(1'b0, 2'd1);
        repeat (4) begin
            tx = 8'($urandom());
            rx = 8'($urandom());
            do_transfer(tx, rx);
        end
        end_test("lsb first random bytes");

        w0 = windows;
        for (int c = 0; c < 4; c++) begin
            set_ctrl(1'b1, c[1:0]);
            do_transfer(8'($urandom()), 8'($urandom()));
        end
        check_val("ss_n windows", windows - w0, 32'd4);
        end_test("sclk timing per cdiv");

        set_ctrl(1'b1, 2'd3);                         // slow for a long busy window
        tx = 8'($urandom());
        rx = 8'($urandom());
        start_transfer(tx, rx);
        wait_select();
        apb_write(a_tx, {24'd0, ~tx}, err);
        check_val("pslverr", err, 32'd1);
        wait_deselect();
        check_transfer(tx, rx);
        end_test("txdata write while busy");

        set_ctrl(1'b1, 2'd0);
        tx = 8'($urandom());
        rx = 8'($urandom());
        start_transfer(tx, rx);
        wait_select();
        set_ctrl(1'b1, 2'd2);                         // mid transfer
        apb_read(a_ctrl, rd);
        check_val("ctrl", rd, 32'h6);
        wait_deselect();
        check_transfer(tx, rx);
        do_transfer(8'($urandom()), 8'($urandom())); // picks up cdiv 2
        end_test("ctrl write during transfer");

        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
logic/spi_pkg.sv
logic/spi_ctrl_if.sv
logic/spi_apb_regs.sv
logic/spi_clk_gen.sv
logic/spi_shifter.sv
logic/spi_master_top.sv
tb/spi_slave_model.sv
tb/tb_spi_master.sv

// ==== run.sh ====
#!/bin/sh
# build and run the SPI master testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_spi_master -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
    exit 0
fi
exit 1
